// ==== common/sramWrapperPkg.sv ====
// ------------------------------------------------
// Shared widths, depth, FSM codes and the address
// decode for the AXI SRAM slave
// ------------------------------------------------
`default_nettype none

package sramWrapperPkg;

    // AXI field widths
    localparam int ID_W   = 8;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    // Burst length field, 0 means one beat
    localparam int LEN_W  = 4;

    // SRAM geometry, 16K words of 32 bits
    localparam int WORD_ADDR_W = 14;
    localparam int MEM_DEPTH   = 16384;

    // Write FSM codes
    localparam logic [1:0] W_IDLE = 2'd0;
    localparam logic [1:0] W_DATA = 2'd1;
    localparam logic [1:0] W_RESP = 2'd2;

    // Read FSM codes
    localparam logic [1:0] R_IDLE    = 2'd0;
    localparam logic [1:0] R_ISSUE   = 2'd1;
    localparam logic [1:0] R_WAIT    = 2'd2;
    localparam logic [1:0] R_PRESENT = 2'd3;

    // One AXI address seen either as a byte address
    // or split into word index and byte offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            // Upper bits above the 64 KB window
            logic [ADDR_W-WORD_ADDR_W-3:0] unused;
            logic [WORD_ADDR_W-1:0]        wordIdx;
            logic [1:0]                    byteOff;
        } fields;
    } axiAddrT;

endpackage

`default_nettype wire

// ==== axiSlave/writeChannel.sv ====
// ------------------------------------------------
// AXI write burst FSM; takes the address, streams
// strobed beats into the SRAM, then answers on B
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module writeChannel (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic [sramWrapperPkg::ID_W-1:0]        AWID,
    input  logic [sramWrapperPkg::ADDR_W-1:0]      AWADDR,
    input  logic [sramWrapperPkg::LEN_W-1:0]       AWLEN,
    input  logic                                   AWVALID,
    output logic                                   AWREADY,
    input  logic [sramWrapperPkg::DATA_W-1:0]      WDATA,
    input  logic [sramWrapperPkg::STRB_W-1:0]      WSTRB,
    input  logic                                   WLAST,
    input  logic                                   WVALID,
    output logic                                   WREADY,
    output logic [sramWrapperPkg::ID_W-1:0]        BID,
    output logic                                   BVALID,
    input  logic                                   BREADY,
    input  logic                                   writeGrant,
    output logic                                   writeReq,
    output logic                                   writeSel,
    output logic [sramWrapperPkg::WORD_ADDR_W-1:0] writeAddr,
    output logic [sramWrapperPkg::STRB_W-1:0]      writeEn,
    output logic [sramWrapperPkg::DATA_W-1:0]      writeData
);

    logic [1:0]                             state;
    logic [sramWrapperPkg::LEN_W-1:0]       beatsLeft;
    logic [sramWrapperPkg::WORD_ADDR_W-1:0] wordIdx;
    sramWrapperPkg::axiAddrT                awAddr;
    logic                                   awHs;
    logic                                   wHs;
    logic                                   lastBeat;

    assign awAddr = AWADDR;
    assign awHs   = AWVALID && AWREADY;
    assign wHs    = WVALID && WREADY;
    // Burst closes on WLAST, or once the AWLEN count runs out
    assign lastBeat = WLAST || (beatsLeft == '0);

    // Port request from a pending address until the last beat
    assign writeReq = (state == sramWrapperPkg::W_IDLE) ? AWVALID
                                                        : (state == sramWrapperPkg::W_DATA);
    assign AWREADY  = (state == sramWrapperPkg::W_IDLE) && writeGrant;
    assign WREADY   = (state == sramWrapperPkg::W_DATA);
    assign BVALID   = (state == sramWrapperPkg::W_RESP);

    // SRAM write straight off the W handshake
    assign writeSel  = wHs;
    assign writeAddr = wordIdx;
    assign writeEn   = WSTRB & {sramWrapperPkg::STRB_W{wHs}};
    assign writeData = WDATA;

    // ------------------------------------------------
    // Control
    // ------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= sramWrapperPkg::W_IDLE;
            beatsLeft <= '0;
        end else begin
            case (state)
                sramWrapperPkg::W_IDLE: begin
                    if (awHs) begin
                        state     <= sramWrapperPkg::W_DATA;
                        beatsLeft <= AWLEN;
                    end
                end
                sramWrapperPkg::W_DATA: begin
                    // WVALID low just stalls here
                    if (wHs) begin
                        beatsLeft <= beatsLeft - 1'b1;
                        if (lastBeat) begin
                            state <= sramWrapperPkg::W_RESP;
                        end
                    end
                end
                sramWrapperPkg::W_RESP: begin
                    if (BREADY) begin
                        state <= sramWrapperPkg::W_IDLE;
                    end
                end
                default: state <= sramWrapperPkg::W_IDLE;
            endcase
        end
    end

    // ID and word pointer, base taken from the decoded address
    always_ff @(posedge clk) begin
        if (awHs) begin
            BID     <= AWID;
            wordIdx <= awAddr.fields.wordIdx;
        end else if (wHs) begin
            wordIdx <= wordIdx + 1'b1;
        end
    end

    // Data phase only opens after an accepted address
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(WREADY) |-> $past(AWVALID && AWREADY));

endmodule

`default_nettype wire

// ==== axiSlave/readChannel.sv ====
// ------------------------------------------------
// AXI read burst FSM; one beat in flight, each word
// held in a register until RREADY takes it
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module readChannel (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic [sramWrapperPkg::ID_W-1:0]        ARID,
    input  logic [sramWrapperPkg::ADDR_W-1:0]      ARADDR,
    input  logic [sramWrapperPkg::LEN_W-1:0]       ARLEN,
    input  logic                                   ARVALID,
    output logic                                   ARREADY,
    output logic [sramWrapperPkg::ID_W-1:0]        RID,
    output logic [sramWrapperPkg::DATA_W-1:0]      RDATA,
    output logic                                   RLAST,
    output logic                                   RVALID,
    input  logic                                   RREADY,
    input  logic                                   readGrant,
    input  logic [sramWrapperPkg::DATA_W-1:0]      readData,
    output logic                                   readReq,
    output logic                                   readSel,
    output logic [sramWrapperPkg::WORD_ADDR_W-1:0] readAddr
);

    logic [1:0]                             state;
    logic [sramWrapperPkg::LEN_W-1:0]       lenReg;
    logic [sramWrapperPkg::LEN_W-1:0]       beatCnt;
    logic [sramWrapperPkg::WORD_ADDR_W-1:0] nextIdx;
    sramWrapperPkg::axiAddrT                arAddr;
    logic                                   arHs;
    logic                                   rHs;

    assign arAddr = ARADDR;
    assign arHs   = ARVALID && ARREADY;
    assign rHs    = RVALID && RREADY;

    // Hold the port for the whole burst
    assign readReq = (state == sramWrapperPkg::R_IDLE) ? ARVALID : 1'b1;
    assign ARREADY = (state == sramWrapperPkg::R_IDLE) && readGrant;
    assign RVALID  = (state == sramWrapperPkg::R_PRESENT);

    // One SRAM read per beat
    assign readSel  = (state == sramWrapperPkg::R_ISSUE);
    assign readAddr = nextIdx;

    // ------------------------------------------------
    // Control
    // ------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= sramWrapperPkg::R_IDLE;
            beatCnt <= '0;
            RLAST   <= 1'b0;
        end else begin
            case (state)
                sramWrapperPkg::R_IDLE: begin
                    if (arHs) begin
                        state   <= sramWrapperPkg::R_ISSUE;
                        beatCnt <= '0;
                    end
                end
                sramWrapperPkg::R_ISSUE: state <= sramWrapperPkg::R_WAIT;
                sramWrapperPkg::R_WAIT: begin
                    // Word lands this cycle, flag the final beat
                    state <= sramWrapperPkg::R_PRESENT;
                    RLAST <= (beatCnt == lenReg);
                end
                sramWrapperPkg::R_PRESENT: begin
                    if (rHs) begin
                        RLAST <= 1'b0;
                        if (RLAST) begin
                            state <= sramWrapperPkg::R_IDLE;
                        end else begin
                            state   <= sramWrapperPkg::R_ISSUE;
                            beatCnt <= beatCnt + 1'b1;
                        end
                    end
                end
                default: state <= sramWrapperPkg::R_IDLE;
            endcase
        end
    end

    // Burst payload and the data holding register
    always_ff @(posedge clk) begin
        if (arHs) begin
            RID     <= ARID;
            lenReg  <= ARLEN;
            nextIdx <= arAddr.fields.wordIdx;
        end else if (state == sramWrapperPkg::R_ISSUE) begin
            nextIdx <= nextIdx + 1'b1;
        end
        if (state == sramWrapperPkg::R_WAIT) begin
            RDATA <= readData;
        end
    end

    // Held beat must not change under back-pressure
    assert property (@(posedge clk) disable iff (!resetn)
        RVALID && !RREADY |=> $stable(RDATA));

    // Last flag only ever rides on a valid beat
    assert property (@(posedge clk) disable iff (!resetn)
        RLAST |-> RVALID);

endmodule

`default_nettype wire

// ==== src/sramPortMux.sv ====
// ------------------------------------------------
// Single SRAM port arbiter; one channel owns the
// port per burst, write wins a tie
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sramPortMux (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   writeReq,
    input  logic                                   readReq,
    input  logic                                   writeSel,
    input  logic [sramWrapperPkg::WORD_ADDR_W-1:0] writeAddr,
    input  logic [sramWrapperPkg::STRB_W-1:0]      writeEn,
    input  logic [sramWrapperPkg::DATA_W-1:0]      writeData,
    input  logic                                   readSel,
    input  logic [sramWrapperPkg::WORD_ADDR_W-1:0] readAddr,
    output logic                                   writeGrant,
    output logic                                   readGrant,
    output logic                                   memSel,
    output logic [sramWrapperPkg::WORD_ADDR_W-1:0] memAddr,
    output logic [sramWrapperPkg::STRB_W-1:0]      memWriteEn,
    output logic [sramWrapperPkg::DATA_W-1:0]      memWriteData
);

    logic ownerValid;
    logic ownerWrite;

    // Free port goes straight to a requester, else stays with owner
    always_comb begin
        if (ownerValid) begin
            writeGrant = ownerWrite && writeReq;
            readGrant  = !ownerWrite && readReq;
        end else begin
            writeGrant = writeReq;
            readGrant  = readReq && !writeReq;
        end
    end

    // Owner drops once its request falls
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ownerValid <= 1'b0;
            ownerWrite <= 1'b0;
        end else begin
            ownerValid <= writeGrant || readGrant;
            ownerWrite <= writeGrant;
        end
    end

    // Route the granted channel
    assign memSel       = writeGrant ? writeSel : (readGrant && readSel);
    assign memAddr      = writeGrant ? writeAddr : readAddr;
    assign memWriteEn   = writeGrant ? writeEn : '0;
    assign memWriteData = writeData;

    assert property (@(posedge clk) disable iff (!resetn)
        !(writeGrant && readGrant));

endmodule

`default_nettype wire

// ==== src/sramArray.sv ====
// ------------------------------------------------
// Behavioral single-port SRAM with byte enables;
// read word shows up one edge after the select
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sramArray (
    input  logic                                   clk,
    input  logic                                   memSel,
    input  logic [sramWrapperPkg::WORD_ADDR_W-1:0] memAddr,
    input  logic [sramWrapperPkg::STRB_W-1:0]      memWriteEn,
    input  logic [sramWrapperPkg::DATA_W-1:0]      memWriteData,
    output logic [sramWrapperPkg::DATA_W-1:0]      memReadData
);

    localparam int BYTE_W = sramWrapperPkg::DATA_W / sramWrapperPkg::STRB_W;

    logic [sramWrapperPkg::DATA_W-1:0] mem [sramWrapperPkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (memSel) begin
            // Byte lanes written independently
            for (int b = 0; b < sramWrapperPkg::STRB_W; b++) begin
                if (memWriteEn[b]) begin
                    mem[memAddr][b*BYTE_W +: BYTE_W] <= memWriteData[b*BYTE_W +: BYTE_W];
                end
            end
            // No lanes enabled means a read
            if (memWriteEn == '0) begin
                memReadData <= mem[memAddr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sramWrapper.sv ====
// ------------------------------------------------
// Top level of the AXI SRAM slave; ties write and
// read channels through the port arbiter to the SRAM
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sramWrapper (
    input  logic                                clk,
    input  logic                                resetn,
    // Write address
    input  logic [sramWrapperPkg::ID_W-1:0]     AWID,
    input  logic [sramWrapperPkg::ADDR_W-1:0]   AWADDR,
    input  logic [sramWrapperPkg::LEN_W-1:0]    AWLEN,
    input  logic                                AWVALID,
    output logic                                AWREADY,
    // Write data
    input  logic [sramWrapperPkg::DATA_W-1:0]   WDATA,
    input  logic [sramWrapperPkg::STRB_W-1:0]   WSTRB,
    input  logic                                WLAST,
    input  logic                                WVALID,
    output logic                                WREADY,
    // Write response
    output logic [sramWrapperPkg::ID_W-1:0]     BID,
    output logic                                BVALID,
    input  logic                                BREADY,
    // Read address
    input  logic [sramWrapperPkg::ID_W-1:0]     ARID,
    input  logic [sramWrapperPkg::ADDR_W-1:0]   ARADDR,
    input  logic [sramWrapperPkg::LEN_W-1:0]    ARLEN,
    input  logic                                ARVALID,
    output logic                                ARREADY,
    // Read data
    output logic [sramWrapperPkg::ID_W-1:0]     RID,
    output logic [sramWrapperPkg::DATA_W-1:0]   RDATA,
    output logic                                RLAST,
    output logic                                RVALID,
    input  logic                                RREADY
);

    // ------------------------------------------------
    // Channel to arbiter wires
    // ------------------------------------------------
    logic                                    writeReq;
    logic                                    writeGrant;
    logic                                    writeSel;
    logic [sramWrapperPkg::WORD_ADDR_W-1:0]  writeAddr;
    logic [sramWrapperPkg::STRB_W-1:0]       writeEn;
    logic [sramWrapperPkg::DATA_W-1:0]       writeData;
    logic                                    readReq;
    logic                                    readGrant;
    logic                                    readSel;
    logic [sramWrapperPkg::WORD_ADDR_W-1:0]  readAddr;

    // Arbiter to SRAM wires
    logic                                    memSel;
    logic [sramWrapperPkg::WORD_ADDR_W-1:0]  memAddr;
    logic [sramWrapperPkg::STRB_W-1:0]       memWriteEn;
    logic [sramWrapperPkg::DATA_W-1:0]       memWriteData;
    logic [sramWrapperPkg::DATA_W-1:0]       memReadData;

    writeChannel u_writeChannel (
        .clk(clk), .resetn(resetn),
        .AWID(AWID), .AWADDR(AWADDR), .AWLEN(AWLEN),
        .AWVALID(AWVALID), .AWREADY(AWREADY),
        .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST),
        .WVALID(WVALID), .WREADY(WREADY),
        .BID(BID), .BVALID(BVALID), .BREADY(BREADY),
        .writeGrant(writeGrant), .writeReq(writeReq),
        .writeSel(writeSel), .writeAddr(writeAddr),
        .writeEn(writeEn), .writeData(writeData)
    );

    readChannel u_readChannel (
        .clk(clk), .resetn(resetn),
        .ARID(ARID), .ARADDR(ARADDR), .ARLEN(ARLEN),
        .ARVALID(ARVALID), .ARREADY(ARREADY),
        .RID(RID), .RDATA(RDATA), .RLAST(RLAST),
        .RVALID(RVALID), .RREADY(RREADY),
        .readGrant(readGrant), .readData(memReadData),
        .readReq(readReq), .readSel(readSel), .readAddr(readAddr)
    );

    sramPortMux u_sramPortMux (
        .clk(clk), .resetn(resetn),
        .writeReq(writeReq), .readReq(readReq),
        .writeSel(writeSel), .writeAddr(writeAddr),
        .writeEn(writeEn), .writeData(writeData),
        .readSel(readSel), .readAddr(readAddr),
        .writeGrant(writeGrant), .readGrant(readGrant),
        .memSel(memSel), .memAddr(memAddr),
        .memWriteEn(memWriteEn), .memWriteData(memWriteData)
    );

    sramArray u_sramArray (
        .clk(clk),
        .memSel(memSel),
        .memAddr(memAddr),
        .memWriteEn(memWriteEn),
        .memWriteData(memWriteData),
        .memReadData(memReadData)
    );

endmodule

`default_nettype wire

// ==== dv/sramWrapperTb.sv ====
// ------------------------------------------------
// Directed testbench for the AXI SRAM slave; bursts
// are checked against a reference memory
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sramWrapperTb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk = 1'b0;
    logic        resetn;
    logic [7:0]  AWID, ARID, BID, RID;
    logic [31:0] AWADDR, ARADDR, WDATA, RDATA;
    logic [3:0]  AWLEN, ARLEN, WSTRB;
    logic        AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
    logic        ARVALID, ARREADY, RLAST, RVALID, RREADY;

    // Expected SRAM contents, one entry per word
    logic [31:0] refMem [0:16383];
    logic [31:0] lcgState = 32'h80b3;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    sramWrapper u_sramWrapper (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Byte lane i taken from the new word when strb[i] is set
    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0] strb);
        logic [31:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = newWord[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // ------------------------------------------------
    // Bus tasks that start and end on a rising edge
    // ------------------------------------------------
    // Beat i carries seedData + i under one strobe for all beats
    task automatic writeBurst(input logic [7:0] id, input logic [31:0] addr,
                              input logic [3:0] len, input logic [31:0] seedData,
                              input logic [3:0] strb);
        int          beat;
        logic [13:0] idx;
        beat = 0;
        idx  = addr[15:2];
        AWID    <= id;
        AWADDR  <= addr;
        AWLEN   <= len;
        AWVALID <= 1'b1;
        @(negedge clk);
        while (!AWREADY) @(negedge clk);
        @(posedge clk);
        AWVALID <= 1'b0;
        while (beat <= len) begin
            WDATA  <= seedData + beat;
            WSTRB  <= strb;
            WLAST  <= (beat == len);
            WVALID <= 1'b1;
            @(negedge clk);
            while (!WREADY) @(negedge clk);
            @(posedge clk);
            refMem[idx + beat] = mergeBytes(refMem[idx + beat], seedData + beat, strb);
            beat++;
        end
        WVALID <= 1'b0;
        WLAST  <= 1'b0;
        BREADY <= 1'b1;
        @(negedge clk);
        while (!BVALID) @(negedge clk);
        checkEq("BID", BID, id);
        @(posedge clk);
        BREADY <= 1'b0;
    endtask

    // Optional random RREADY stall from the LCG
    task automatic readBurst(input logic [7:0] id, input logic [31:0] addr,
                             input logic [3:0] len, input logic stall);
        int          beat;
        logic [13:0] idx;
        logic [31:0] randWord;
        beat = 0;
        idx  = addr[15:2];
        ARID    <= id;
        ARADDR  <= addr;
        ARLEN   <= len;
        ARVALID <= 1'b1;
        @(negedge clk);
        while (!ARREADY) @(negedge clk);
        @(posedge clk);
        ARVALID <= 1'b0;
        while (beat <= len) begin
            randWord = nextRand();
            RREADY <= stall ? randWord[16] : 1'b1;
            @(negedge clk);
            if (RVALID && RREADY) begin
                checkEq("RDATA", RDATA, refMem[idx + beat]);
                checkEq("RID", RID, id);
                checkEq("RLAST", RLAST, beat == len);
                beat++;
            end
            @(posedge clk);
        end
        RREADY <= 1'b0;
        // No extra beat after the last one, a new word would show within three cycles
        repeat (3) begin
            @(negedge clk);
            checkEq("RVALID", RVALID, 1'b0);
        end
        @(posedge clk);
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        resetn  <= 1'b0;
        AWID    <= '0;
        AWADDR  <= '0;
        AWLEN   <= '0;
        AWVALID <= 1'b0;
        WDATA   <= '0;
        WSTRB   <= '0;
        WLAST   <= 1'b0;
        WVALID  <= 1'b0;
        BREADY  <= 1'b0;
        ARID    <= '0;
        ARADDR  <= '0;
        ARLEN   <= '0;
        ARVALID <= 1'b0;
        RREADY  <= 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        // Idle outputs after reset
        @(negedge clk);
        checkEq("AWREADY", AWREADY, 1'b0);
        checkEq("WREADY", WREADY, 1'b0);
        checkEq("BVALID", BVALID, 1'b0);
        checkEq("ARREADY", ARREADY, 1'b0);
        checkEq("RVALID", RVALID, 1'b0);
        checkEq("RLAST", RLAST, 1'b0);
        @(posedge clk);
        // Single beat each way
        writeBurst(8'h3c, 32'h0000_0100, 4'd0, 32'hdead_beef, 4'hf);
        readBurst(8'h5a, 32'h0000_0100, 4'd0, 1'b0);
        // Four beat bursts
        writeBurst(8'h11, 32'h0000_0200, 4'd3, 32'h1000_0000, 4'hf);
        readBurst(8'h22, 32'h0000_0200, 4'd3, 1'b0);
        // Byte strobes 0101 over a full word
        writeBurst(8'h01, 32'h0000_0300, 4'd0, 32'haabb_ccdd, 4'hf);
        writeBurst(8'h02, 32'h0000_0300, 4'd0, 32'h1122_3344, 4'h5);
        readBurst(8'h03, 32'h0000_0300, 4'd0, 1'b0);
        // Eight beats under random back-pressure
        writeBurst(8'h44, 32'h0000_0400, 4'd7, 32'h4000_0000, 4'hf);
        readBurst(8'h55, 32'h0000_0400, 4'd7, 1'b1);
        // Same address on both channels where the write lands first
        writeBurst(8'h66, 32'h0000_0500, 4'd0, 32'h0bad_f00d, 4'hf);
        // Write wins the tie so the read must see the new word
        refMem[32'h0000_0500 >> 2] = 32'h600d_cafe;
        fork
            writeBurst(8'h77, 32'h0000_0500, 4'd0, 32'h600d_cafe, 4'hf);
            readBurst(8'h88, 32'h0000_0500, 4'd0, 1'b0);
        join
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run limit well above the length of the whole sequence
    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: no finish within %0d cycles, a handshake never came",
                 TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/sramWrapperPkg.sv
axiSlave/writeChannel.sv
axiSlave/readChannel.sv
src/sramPortMux.sv
src/sramArray.sv
src/sramWrapper.sv
dv/sramWrapperTb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := sramWrapperTb
FILELIST := sources.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
